//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module cpuCoreTb

sim:
	verilator --binary --timing --assert -f sim.f --top-module cpuCoreTb \
		-Mdir obj_dir -o cpuCoreTb
	@out="$$(./obj_dir/cpuCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import mipsPkg::*;
(
    input  wire  [31:0] a_i,
    input  wire  [31:0] b_i,
    input  wire  [4:0]  shamt_i,
    input  wire  aluOpT op_i,
    output logic [31:0] result_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            // signed compare
            ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLL: result_o = b_i << shamt_i;
            // immediate into the upper half
            ALU_LUI: result_o = {b_i[15:0], 16'h0000};
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore
    import mipsPkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'hBFC0_0000
) (
    input  wire         clk,
    input  wire         rst_i,
    output logic        instEn_o,
    output logic [31:0] instAddr_o,
    input  wire  [31:0] instData_i,
    input  wire         instStall_i,
    output logic        dataEn_o,
    output logic [3:0]  dataWen_o,
    output logic [31:0] dataAddr_o,
    output logic [31:0] dataWdata_o,
    input  wire  [31:0] dataRdata_i,
    input  wire         dataStall_i
);

    opcodeT                opD;
    functT                 functD;
    logic [REG_ADDR_W-1:0] rsD, rtD, rsE, rtE, dstE, dstM, dstW;
    logic                  regWriteE, regWriteM, regWriteW, memToRegE, memToRegM, branchD;
    logic                  regWrite, regDst, aluSrcImm, zeroExt, shiftSa, memToReg;
    logic                  memWrite, branchEq, branchNe, jump, link;
    aluOpT                 aluOp;
    fwdSelT                fwdAE, fwdBE;
    logic                  fwdAD, fwdBD, flushE;
    logic                  stallF, stallD, stallE, stallM, stallW;

    datapath #(
        .RESET_PC(RESET_PC)
    ) datapath (
        .clk(clk), .rst_i(rst_i),
        .instData_i(instData_i), .dataRdata_i(dataRdata_i),
        .instEn_o(instEn_o), .instAddr_o(instAddr_o),
        .dataEn_o(dataEn_o), .dataWen_o(dataWen_o),
        .dataAddr_o(dataAddr_o), .dataWdata_o(dataWdata_o),
        .opD_o(opD), .functD_o(functD), .rsD_o(rsD), .rtD_o(rtD),
        .rsE_o(rsE), .rtE_o(rtE), .dstE_o(dstE), .dstM_o(dstM), .dstW_o(dstW),
        .regWriteE_o(regWriteE), .regWriteM_o(regWriteM), .regWriteW_o(regWriteW),
        .memToRegE_o(memToRegE), .memToRegM_o(memToRegM), .branchD_o(branchD),
        .regWrite_i(regWrite), .regDst_i(regDst), .aluSrcImm_i(aluSrcImm),
        .zeroExt_i(zeroExt), .shiftSa_i(shiftSa), .memToReg_i(memToReg),
        .memWrite_i(memWrite), .branchEq_i(branchEq), .branchNe_i(branchNe),
        .jump_i(jump), .link_i(link), .aluOp_i(aluOp),
        .fwdAE_i(fwdAE), .fwdBE_i(fwdBE), .fwdAD_i(fwdAD), .fwdBD_i(fwdBD),
        .stallF_i(stallF), .stallD_i(stallD), .stallE_i(stallE),
        .stallM_i(stallM), .stallW_i(stallW), .flushE_i(flushE)
    );

    mainDecoder mainDecoder (
        .op_i(opD), .funct_i(functD),
        .regWrite_o(regWrite), .regDst_o(regDst), .aluSrcImm_o(aluSrcImm),
        .zeroExt_o(zeroExt), .shiftSa_o(shiftSa), .memToReg_o(memToReg),
        .memWrite_o(memWrite), .branchEq_o(branchEq), .branchNe_o(branchNe),
        .jump_o(jump), .link_o(link), .aluOp_o(aluOp)
    );

    hazardUnit hazardUnit (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .dstE_i(dstE), .dstM_i(dstM), .dstW_i(dstW),
        .regWriteE_i(regWriteE), .regWriteM_i(regWriteM), .regWriteW_i(regWriteW),
        .memToRegE_i(memToRegE), .memToRegM_i(memToRegM), .branchD_i(branchD),
        .instStall_i(instStall_i), .dataStall_i(dataStall_i),
        .fwdAE_o(fwdAE), .fwdBE_o(fwdBE), .fwdAD_o(fwdAD), .fwdBD_o(fwdBD),
        .stallF_o(stallF), .stallD_o(stallD), .stallE_o(stallE),
        .stallM_o(stallM), .stallW_o(stallW), .flushE_o(flushE)
    );

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath
    import mipsPkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'hBFC0_0000
) (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire  [31:0]           instData_i,
    input  wire  [31:0]           dataRdata_i,
    output logic                  instEn_o,
    output logic [31:0]           instAddr_o,
    output logic                  dataEn_o,
    output logic [3:0]            dataWen_o,
    output logic [31:0]           dataAddr_o,
    output logic [31:0]           dataWdata_o,
    output opcodeT                opD_o,
    output functT                 functD_o,
    output logic [REG_ADDR_W-1:0] rsD_o, rtD_o, rsE_o, rtE_o,
    output logic [REG_ADDR_W-1:0] dstE_o, dstM_o, dstW_o,
    output logic                  regWriteE_o, regWriteM_o, regWriteW_o,
    output logic                  memToRegE_o, memToRegM_o, branchD_o,
    input  wire                   regWrite_i, regDst_i, aluSrcImm_i, zeroExt_i,
    input  wire                   shiftSa_i, memToReg_i, memWrite_i,
    input  wire                   branchEq_i, branchNe_i, jump_i, link_i,
    input  wire  aluOpT           aluOp_i,
    input  wire  fwdSelT          fwdAE_i,
    input  wire  fwdSelT          fwdBE_i,
    input  wire                   fwdAD_i, fwdBD_i,
    input  wire                   stallF_i, stallD_i, stallE_i, stallM_i, stallW_i,
    input  wire                   flushE_i
);

    logic [31:0]           pcF, pcPlus4F, pcNext;
    logic [31:0]           instrD, pcPlus4D, rd1D, rd2D, cmpAD, cmpBD, immD;
    logic                  takenD;
    logic                  regDstE, aluSrcImmE, shiftSaE, memWriteE, linkE;
    aluOpT                 aluOpE;
    logic [REG_ADDR_W-1:0] rdE;
    logic [4:0]            saE;
    logic [31:0]           rd1E, rd2E, immE, pcPlus4E, srcAE, srcBE, aluOutE, resultE;
    logic                  memWriteM;
    logic [31:0]           aluResM, wdataM, wbDataW;

    // fetch
    assign pcPlus4F   = pcF + 32'd4;
    assign instEn_o   = 1'b1;
    assign instAddr_o = pcF;

    // redirect from decode while the delay slot sits in fetch
    always_comb begin
        if (jump_i) begin
            pcNext = {pcPlus4D[31:28], instrD[25:0], 2'b00};
        end else if (takenD) begin
            pcNext = pcPlus4D + {immD[29:0], 2'b00};
        end else begin
            pcNext = pcPlus4F;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pcF <= RESET_PC;
        end else if (!stallF_i) begin
            pcF <= pcNext;
        end
    end

    // decode
    always_ff @(posedge clk) begin
        if (rst_i) begin
            instrD <= '0;
        end else if (!stallD_i) begin
            instrD   <= instData_i;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign opD_o     = opcodeT'(instrD[31:26]);
    assign functD_o  = functT'(instrD[5:0]);
    assign rsD_o     = instrD[25:21];
    assign rtD_o     = instrD[20:16];
    assign branchD_o = branchEq_i | branchNe_i;
    assign immD      = zeroExt_i ? {16'h0000, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

    regFile regFile (
        .clk(clk), .rst_i(rst_i), .we_i(regWriteW_o),
        .raddr1_i(rsD_o), .raddr2_i(rtD_o), .waddr_i(dstW_o), .wdata_i(wbDataW),
        .rdata1_o(rd1D), .rdata2_o(rd2D)
    );

    // branch compare sees the memory stage result
    assign cmpAD  = fwdAD_i ? aluResM : rd1D;
    assign cmpBD  = fwdBD_i ? aluResM : rd2D;
    assign takenD = (branchEq_i && cmpAD == cmpBD) || (branchNe_i && cmpAD != cmpBD);

    // execute
    always_ff @(posedge clk) begin
        if (rst_i || flushE_i) begin
            regWriteE_o <= 1'b0;
            memToRegE_o <= 1'b0;
            memWriteE   <= 1'b0;
            linkE       <= 1'b0;
        end else if (!stallE_i) begin
            regWriteE_o <= regWrite_i;
            memToRegE_o <= memToReg_i;
            memWriteE   <= memWrite_i;
            linkE       <= link_i;
            regDstE     <= regDst_i;
            aluSrcImmE  <= aluSrcImm_i;
            shiftSaE    <= shiftSa_i;
            aluOpE      <= aluOp_i;
            rsE_o       <= rsD_o;
            rtE_o       <= rtD_o;
            rdE         <= instrD[15:11];
            saE         <= instrD[10:6];
            rd1E        <= rd1D;
            rd2E        <= rd2D;
            immE        <= immD;
            pcPlus4E    <= pcPlus4D;
        end
    end

    // JAL links to $ra
    assign dstE_o = linkE ? {REG_ADDR_W{1'b1}} : (regDstE ? rdE : rtE_o);

    always_comb begin
        case (fwdAE_i)
            FWD_MEM: srcAE = aluResM;
            FWD_WB:  srcAE = wbDataW;
            default: srcAE = rd1E;
        endcase
        case (fwdBE_i)
            FWD_MEM: srcBE = aluResM;
            FWD_WB:  srcBE = wbDataW;
            default: srcBE = rd2E;
        endcase
    end

    alu alu (
        .a_i(srcAE), .b_i(aluSrcImmE ? immE : srcBE),
        .shamt_i(shiftSaE ? saE : srcAE[4:0]), .op_i(aluOpE), .result_o(aluOutE)
    );

    // return address skips the delay slot
    assign resultE = linkE ? pcPlus4E + 32'd4 : aluOutE;

    // memory
    always_ff @(posedge clk) begin
        if (rst_i) begin
            regWriteM_o <= 1'b0;
            memToRegM_o <= 1'b0;
            memWriteM   <= 1'b0;
        end else if (!stallM_i) begin
            regWriteM_o <= regWriteE_o;
            memToRegM_o <= memToRegE_o;
            memWriteM   <= memWriteE;
            dstM_o      <= dstE_o;
            aluResM     <= resultE;
            wdataM      <= srcBE;
        end
    end

    assign dataEn_o    = memToRegM_o | memWriteM;
    assign dataWen_o   = {4{memWriteM}};
    assign dataWdata_o = wdataM;

    // kseg0 and kseg1 drop the segment bits and other segments map to zero
    assign dataAddr_o = (aluResM[31:30] == 2'b10) ? {3'b000, aluResM[28:0]} : 32'h0;

    // writeback
    always_ff @(posedge clk) begin
        if (rst_i) begin
            regWriteW_o <= 1'b0;
        end else if (!stallW_i) begin
            regWriteW_o <= regWriteM_o;
            dstW_o      <= dstM_o;
            wbDataW     <= memToRegM_o ? dataRdata_i : aluResM;
        end
    end

endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit
    import mipsPkg::*;
(
    input  wire  [REG_ADDR_W-1:0] rsD_i, rtD_i,
    input  wire  [REG_ADDR_W-1:0] rsE_i, rtE_i,
    input  wire  [REG_ADDR_W-1:0] dstE_i, dstM_i, dstW_i,
    input  wire                   regWriteE_i, regWriteM_i, regWriteW_i,
    input  wire                   memToRegE_i, memToRegM_i,
    input  wire                   branchD_i,
    input  wire                   instStall_i,
    input  wire                   dataStall_i,
    output fwdSelT                fwdAE_o,
    output fwdSelT                fwdBE_o,
    output logic                  fwdAD_o, fwdBD_o,
    output logic                  stallF_o, stallD_o, stallE_o, stallM_o, stallW_o,
    output logic                  flushE_o
);

    logic lwStall;
    logic branchStall;
    logic extStall;

    // $zero never forwards
    function automatic logic hits(input logic [REG_ADDR_W-1:0] dst,
                                  input logic [REG_ADDR_W-1:0] src);
        return (src != '0) && (dst == src);
    endfunction

    // memory stage is newer than writeback
    function automatic fwdSelT pickSrc(input logic [REG_ADDR_W-1:0] src);
        if (regWriteM_i && hits(dstM_i, src)) begin
            return FWD_MEM;
        end
        if (regWriteW_i && hits(dstW_i, src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwdAE_o = pickSrc(rsE_i);
        fwdBE_o = pickSrc(rtE_i);
        fwdAD_o = regWriteM_i && hits(dstM_i, rsD_i);
        fwdBD_o = regWriteM_i && hits(dstM_i, rtD_i);
    end

    always_comb begin
        lwStall = memToRegE_i && (hits(dstE_i, rsD_i) || hits(dstE_i, rtD_i));
        // compare in decode needs settled operands
        branchStall = branchD_i &&
            ((regWriteE_i && (hits(dstE_i, rsD_i) || hits(dstE_i, rtD_i))) ||
             (memToRegM_i && (hits(dstM_i, rsD_i) || hits(dstM_i, rtD_i))));
        extStall = instStall_i || dataStall_i;
        stallF_o = lwStall || branchStall || extStall;
        stallD_o = stallF_o;
        // memory latency freezes everything
        stallE_o = extStall;
        stallM_o = extStall;
        stallW_o = extStall;
        flushE_o = (lwStall || branchStall) && !extStall;
        assert (!(flushE_o && stallE_o))
            else $error("execute flushed while held");
    end

endmodule

`default_nettype wire

//--- hw/mainDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module mainDecoder
    import mipsPkg::*;
(
    input  wire   opcodeT op_i,
    input  wire   functT  funct_i,
    output logic  regWrite_o,
    output logic  regDst_o,
    output logic  aluSrcImm_o,
    output logic  zeroExt_o,
    output logic  shiftSa_o,
    output logic  memToReg_o,
    output logic  memWrite_o,
    output logic  branchEq_o,
    output logic  branchNe_o,
    output logic  jump_o,
    output logic  link_o,
    output aluOpT aluOp_o
);

    always_comb begin
        regWrite_o  = 1'b0;
        regDst_o    = 1'b0;
        aluSrcImm_o = 1'b0;
        zeroExt_o   = 1'b0;
        shiftSa_o   = 1'b0;
        memToReg_o  = 1'b0;
        memWrite_o  = 1'b0;
        branchEq_o  = 1'b0;
        branchNe_o  = 1'b0;
        jump_o      = 1'b0;
        link_o      = 1'b0;
        aluOp_o     = ALU_ADD;
        case (op_i)
            OP_SPECIAL: begin
                regDst_o   = 1'b1;
                regWrite_o = 1'b1;
                case (funct_i)
                    FN_SLL: begin
                        aluOp_o   = ALU_SLL;
                        shiftSa_o = 1'b1;
                    end
                    FN_ADDU: aluOp_o = ALU_ADD;
                    FN_SUBU: aluOp_o = ALU_SUB;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_SLT:  aluOp_o = ALU_SLT;
                    // unknown function is a no-op
                    default: regWrite_o = 1'b0;
                endcase
            end
            OP_J: jump_o = 1'b1;
            OP_JAL: begin
                jump_o     = 1'b1;
                link_o     = 1'b1;
                regWrite_o = 1'b1;
            end
            OP_BEQ: branchEq_o = 1'b1;
            OP_BNE: branchNe_o = 1'b1;
            OP_ADDIU: begin
                regWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OP_ORI: begin
                regWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
                zeroExt_o   = 1'b1;
                aluOp_o     = ALU_OR;
            end
            OP_LUI: begin
                regWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
                zeroExt_o   = 1'b1;
                aluOp_o     = ALU_LUI;
            end
            OP_LW: begin
                regWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
                memToReg_o  = 1'b1;
            end
            OP_SW: begin
                aluSrcImm_o = 1'b1;
                memWrite_o  = 1'b1;
            end
            default: ;
        endcase
        assert (!(branchEq_o && branchNe_o))
            else $error("decoder drives both branch conditions");
    end

endmodule

`default_nettype wire

//--- hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

    // register index width
    localparam int REG_ADDR_W = 5;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcodeT;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } aluOpT;

    // execute operand sources
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSelT;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile
    import mipsPkg::*;
(
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   we_i,
    input  wire  [REG_ADDR_W-1:0] raddr1_i,
    input  wire  [REG_ADDR_W-1:0] raddr2_i,
    input  wire  [REG_ADDR_W-1:0] waddr_i,
    input  wire  [31:0]           wdata_i,
    output logic [31:0]           rdata1_o,
    output logic [31:0]           rdata2_o
);

    logic [31:0] regs [2**REG_ADDR_W];

    // entry 0 is never written
    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so writeback and decode can share a cycle
    function automatic logic [31:0] readPort(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = readPort(raddr1_i);
        rdata2_o = readPort(raddr2_i);
    end

    // a write aimed at $zero leaves it reading zero afterwards
    assert property (@(posedge clk) disable iff (rst_i)
        (we_i && waddr_i == '0) |=>
            ((raddr1_i != '0 || rdata1_o == '0) && (raddr2_i != '0 || rdata2_o == '0)));

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
hw/mipsPkg.sv
hw/regFile.sv
hw/alu.sv
hw/mainDecoder.sv
hw/hazardUnit.sv
hw/datapath.sv
hw/cpuCore.sv
tb/cpuCoreTb.sv

//--- tb/testProgram.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

// instruction field packing
function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] rd, input logic [4:0] sa,
                                     input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encJ(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
endfunction

localparam int PROG_LEN   = 39;
localparam int PROG_IDX_W = $clog2(PROG_LEN);

// linked at RESET_PC with one word per entry
localparam logic [31:0] PROGRAM [PROG_LEN] = '{
    encI(OP_LUI,   5'd0,  5'd16, 16'hA000),          // kseg1 data base
    encI(OP_LUI,   5'd0,  5'd17, 16'h8000),          // kseg0 data base
    encI(OP_ADDIU, 5'd0,  5'd8,  16'd5),
    encI(OP_ADDIU, 5'd8,  5'd9,  16'd7),
    encR(5'd9,  5'd8,  5'd10, 5'd0, FN_ADDU),
    encR(5'd10, 5'd9,  5'd11, 5'd0, FN_SUBU),
    encR(5'd0,  5'd11, 5'd12, 5'd4, FN_SLL),
    encR(5'd12, 5'd10, 5'd13, 5'd0, FN_OR),
    encI(OP_ADDIU, 5'd0,  5'd14, 16'hFFFD),          // -3
    encR(5'd14, 5'd13, 5'd15, 5'd0, FN_SLT),
    encI(OP_SW,    5'd16, 5'd10, 16'h0000),
    encI(OP_SW,    5'd16, 5'd13, 16'h0004),
    encI(OP_SW,    5'd16, 5'd15, 16'h0008),
    encR(5'd13, 5'd12, 5'd18, 5'd0, FN_AND),
    encI(OP_SW,    5'd16, 5'd18, 16'h000C),
    encI(OP_ORI,   5'd0,  5'd19, 16'h8234),
    encI(OP_SW,    5'd16, 5'd19, 16'h0010),
    encI(OP_LW,    5'd16, 5'd20, 16'h0010),
    encI(OP_ADDIU, 5'd20, 5'd21, 16'h0010),          // load-use
    encI(OP_SW,    5'd16, 5'd21, 16'h0014),
    encI(OP_LW,    5'd16, 5'd23, 16'h0010),
    encI(OP_BEQ,   5'd23, 5'd20, 16'd2),             // taken
    encI(OP_SW,    5'd16, 5'd23, 16'h0018),          // delay slot
    encI(OP_SW,    5'd16, 5'd0,  16'h001C),          // skipped
    encI(OP_ADDIU, 5'd0,  5'd24, 16'h00AA),
    encI(OP_SW,    5'd16, 5'd24, 16'h0020),
    encI(OP_BNE,   5'd24, 5'd24, 16'd3),             // not taken
    encI(OP_SW,    5'd16, 5'd21, 16'h0024),          // delay slot
    encI(OP_ADDIU, 5'd0,  5'd25, 16'h00BB),
    encI(OP_SW,    5'd16, 5'd25, 16'h0028),
    encJ(OP_JAL,   RESET_PC + 32'd132),
    encI(OP_SW,    5'd16, 5'd8,  16'h002C),          // delay slot
    encI(OP_SW,    5'd16, 5'd0,  16'h0030),          // skipped
    encI(OP_SW,    5'd16, 5'd31, 16'h0030),
    encI(OP_SW,    5'd17, 5'd10, 16'h0040),          // through kseg0
    encI(OP_LW,    5'd16, 5'd26, 16'h0040),          // same word via kseg1
    encI(OP_SW,    5'd16, 5'd26, 16'h0034),
    encJ(OP_J,     RESET_PC + 32'd148),              // park here
    32'h0000_0000
};

localparam int TRACE_LEN   = 14;
localparam int TRACE_IDX_W = $clog2(TRACE_LEN);

// store trace as physical address and data per store
localparam logic [31:0] TRACE_ADDR [TRACE_LEN] = '{
    32'h0000_0000, 32'h0000_0004, 32'h0000_0008, 32'h0000_000C,
    32'h0000_0010, 32'h0000_0014, 32'h0000_0018, 32'h0000_0020,
    32'h0000_0024, 32'h0000_0028, 32'h0000_002C, 32'h0000_0030,
    32'h0000_0040,          // kseg0 0x8000_0040 with the top nibble cleared
    32'h0000_0034
};

localparam logic [31:0] TRACE_DATA [TRACE_LEN] = '{
    32'd17,                 // 5 + 7 + 5
    32'h51,                 // (5 << 4) | 17
    32'd1,                  // -3 < 0x51 signed
    32'h50,                 // 0x51 & 0x50
    32'h8234,               // ori zero-extends
    32'h8244,               // loaded value plus 0x10
    32'h8234,
    32'hAA,
    32'h8244,
    32'hBB,
    32'd5,
    RESET_PC + 32'd128,     // jal at word 30 plus 8
    32'd17,
    32'd17
};

`endif

//--- tb/cpuCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCoreTb
    import mipsPkg::*;
();

    localparam logic [31:0] RESET_PC = 32'hBFC0_0000;
    localparam int CLK_NS       = 8;
    localparam int DRIVE_NS     = 1;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 20;

    `include "testProgram.svh"

    // stall headroom on top of the program length
    localparam int WATCHDOG_NS = 4 * PROG_LEN * CLK_NS * 2 +
                                 (RESET_CYCLES + DRAIN_CYCLES) * CLK_NS;

    logic        clk;
    logic        rst;
    logic        instEn;
    logic [31:0] instAddr;
    logic [31:0] instData;
    logic        instStall;
    logic        dataEn;
    logic [3:0]  dataWen;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic [31:0] dataRdata;
    logic        dataStall;

    logic [31:0] instRom [256];
    logic [31:0] dataRam [256];
    logic [31:0] lfsrState;
    int          storeCount;
    logic        storeFire;
    logic [31:0] expAddr;
    logic [31:0] expData;

    cpuCore #(
        .RESET_PC(RESET_PC)
    ) i_dut (
        .clk(clk), .rst_i(rst),
        .instEn_o(instEn), .instAddr_o(instAddr),
        .instData_i(instData), .instStall_i(instStall),
        .dataEn_o(dataEn), .dataWen_o(dataWen),
        .dataAddr_o(dataAddr), .dataWdata_o(dataWdata),
        .dataRdata_i(dataRdata), .dataStall_i(dataStall)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBit(output logic b);
        lfsrState = lfsrNext(lfsrState);
        b = lfsrState[0];
    endtask

    // high with one-in-four odds
    task automatic drawStall(output logic s);
        logic b0;
        logic b1;
        takeBit(b0);
        takeBit(b1);
        s = b0 & b1;
    endtask

    task automatic valueError(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("error: time %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic plainError(input string what);
        $display("time %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // memories answer in the same cycle
    always_comb begin
        instData  = instRom[instAddr[9:2]];
        dataRdata = dataRam[dataAddr[9:2]];
    end

    // the store leaves memory stage only when neither memory stalls
    assign storeFire = !rst && dataEn && (dataWen != 4'h0) && !dataStall && !instStall;

    always_ff @(posedge clk) begin
        if (rst) begin
            storeCount <= 0;
            for (int i = 0; i < 256; i++) begin
                dataRam[i[7:0]] <= 32'hDA7A_0000 ^ (32'(i) << 2);
            end
        end else if (storeFire) begin
            dataRam[dataAddr[9:2]] <= dataWdata;
            storeCount <= storeCount + 1;
        end
    end

    always_comb begin
        expAddr = TRACE_ADDR[storeCount[TRACE_IDX_W-1:0]];
        expData = TRACE_DATA[storeCount[TRACE_IDX_W-1:0]];
    end

    // first cycle out of reset
    assert property (@(posedge clk) $fell(rst) |-> instAddr == RESET_PC)
        else valueError("instAddr_o", RESET_PC, $sampled(instAddr));
    assert property (@(posedge clk) $fell(rst) |-> instEn)
        else valueError("instEn_o", 32'h1, {31'b0, $sampled(instEn)});
    assert property (@(posedge clk) $fell(rst) |-> !dataEn)
        else valueError("dataEn_o", 32'h0, {31'b0, $sampled(dataEn)});
    assert property (@(posedge clk) $fell(rst) |-> dataWen == 4'h0)
        else valueError("dataWen_o", 32'h0, {28'b0, $sampled(dataWen)});

    // each accepted store against the trace
    assert property (@(posedge clk) disable iff (rst) storeFire |-> storeCount < TRACE_LEN)
        else plainError("a store appeared after the last expected one");
    assert property (@(posedge clk) disable iff (rst)
        (storeFire && storeCount < TRACE_LEN) |-> dataAddr == expAddr)
        else valueError("dataAddr_o", $sampled(expAddr), $sampled(dataAddr));
    assert property (@(posedge clk) disable iff (rst)
        (storeFire && storeCount < TRACE_LEN) |-> dataWdata == expData)
        else valueError("dataWdata_o", $sampled(expData), $sampled(dataWdata));
    assert property (@(posedge clk) disable iff (rst) storeFire |-> dataWen == 4'hF)
        else valueError("dataWen_o", 32'hF, {28'b0, $sampled(dataWen)});

    // held requests under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        (dataEn && dataStall) |=>
            (dataEn && $stable(dataWen) && $stable(dataAddr) && $stable(dataWdata)))
        else plainError("the data request moved while the data memory stalled");
    assert property (@(posedge clk) disable iff (rst) instStall |=> $stable(instAddr))
        else plainError("the fetch address moved while the instruction memory stalled");

    initial begin
        #(WATCHDOG_NS);
        plainError("watchdog expired before the store trace completed");
    end

    initial begin
        logic stallBit;
        rst       = 1'b1;
        instStall = 1'b0;
        dataStall = 1'b0;
        lfsrState = 32'd79010;
        for (int i = 0; i < 256; i++) begin
            instRom[i[7:0]] = 32'h0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            instRom[i[7:0]] = PROGRAM[i[PROG_IDX_W-1:0]];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_NS);
        rst = 1'b0;
        while (storeCount < TRACE_LEN) begin
            @(posedge clk);
            #(DRIVE_NS);
            drawStall(stallBit);
            instStall = stallBit;
            drawStall(stallBit);
            dataStall = stallBit;
        end
        instStall = 1'b0;
        dataStall = 1'b0;
        // parked loop must not store again
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (storeCount == TRACE_LEN) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            plainError("store count does not match the trace length");
        end
    end

endmodule

`default_nettype wire
